// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = ctrl_core_tb
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "RESULT: FAIL"; exit 1; \
	else \
		echo "RESULT: PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/core_consts.svh
// constants for the control core: stream IDs, setting addresses and sizes, include where needed
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

////////////////////////////////////////
// stream routing
////////////////////////////////////////

// applied to the low byte of the destination SID
`define CORE_SID_MASK      8'hf0

// masked SIDs of the two control peers
`define CORE_SETTINGS_SID  8'h40
`define CORE_LOOPBACK_SID  8'h20

////////////////////////////////////////
// setting register addresses
////////////////////////////////////////

`define SR_CORE_MISC       8'd16
`define SR_CORE_READBACK   8'd32
`define SR_CORE_SYNC       8'd48

////////////////////////////////////////
// compat and status words
////////////////////////////////////////

`define CORE_COMPAT_MAJOR  16'h0010
`define CORE_COMPAT_MINOR  16'h0000
`define CORE_COMPAT_MAGIC  32'hace0ba5e

// one radio populated, the second control port is loopback
`define CORE_RADIO_STATUS  8'h01

// timing FIFOs hold 32 words
`define CORE_FIFO_DEPTH_LOG2 5

`endif

// File: logic/core_pkg.sv
// shared control word and peer index types, referenced by scoped name from the core modules
package core_pkg;

    // header word of a control packet
    // the low byte of dst_sid selects the peer
    typedef struct packed {
        logic [15:0] seq_num;
        logic [15:0] pkt_len;
        logic [15:0] src_sid;
        logic [15:0] dst_sid;
    } ctrl_hdr_t;

    // command word of a control packet
    typedef struct packed {
        logic [23:0] rsvd;
        logic [7:0]  set_addr;
        logic [31:0] set_data;
    } ctrl_cmd_t;

    // one 64-bit bus word, read as a header or as a command
    typedef union packed {
        ctrl_hdr_t hdr;
        ctrl_cmd_t cmd;
    } ctrl_word_u;

    // index of the control peers on the demux and on the response arbiter
    typedef enum logic {
        PEER_SETTINGS = 1'b0,
        PEER_LOOPBACK = 1'b1
    } peer_sel_e;

endpackage

// File: logic/ctrl_core.sv
// top level of the control core: timing FIFO, demux, settings and loopback peers, response arbiter
`timescale 1ns/1ps

module ctrl_core (
    input  logic        bus_clk,
    input  logic        bus_rst,
    input  logic [63:0] i_ctrl_tdata,
    input  logic        i_ctrl_tlast,
    input  logic        i_ctrl_tvalid,
    output logic        o_ctrl_tready,
    output logic [63:0] o_resp_tdata,
    output logic        o_resp_tlast,
    output logic        o_resp_tvalid,
    input  logic        i_resp_tready,
    input  logic [31:0] i_rb_misc,
    input  logic [1:0]  i_lock_signals,
    output logic [31:0] o_misc_outs,
    output logic [1:0]  o_pps_select,
    output logic        o_time_sync
);

    // timing FIFO to demux
    logic [63:0] ctrl_tdata;
    logic        ctrl_tlast, ctrl_tvalid, ctrl_tready;

    // demux to peers
    logic [63:0] set_tdata, loop_tdata;
    logic        set_tlast, set_tvalid, set_tready;
    logic        loop_tlast, loop_tvalid, loop_tready;

    // peers to arbiter
    logic [63:0] s0_resp_tdata, s1_resp_tdata;
    logic        s0_resp_tlast, s0_resp_tvalid, s0_resp_tready;
    logic        s1_resp_tlast, s1_resp_tvalid, s1_resp_tready;

    ctrl_fifo timing_fifo_i (
        .bus_clk(bus_clk), .bus_rst(bus_rst),
        .i_tdata(i_ctrl_tdata), .i_tlast(i_ctrl_tlast),
        .i_tvalid(i_ctrl_tvalid), .o_tready(o_ctrl_tready),
        .o_tdata(ctrl_tdata), .o_tlast(ctrl_tlast),
        .o_tvalid(ctrl_tvalid), .i_tready(ctrl_tready)
    );

    ctrl_demux ctrl_demux_i (
        .bus_clk(bus_clk), .bus_rst(bus_rst),
        .i_tdata(ctrl_tdata), .i_tlast(ctrl_tlast),
        .i_tvalid(ctrl_tvalid), .o_tready(ctrl_tready),
        .o_set_tdata(set_tdata), .o_set_tlast(set_tlast),
        .o_set_tvalid(set_tvalid), .i_set_tready(set_tready),
        .o_loop_tdata(loop_tdata), .o_loop_tlast(loop_tlast),
        .o_loop_tvalid(loop_tvalid), .i_loop_tready(loop_tready)
    );

    settings_endpoint settings_endpoint_i (
        .bus_clk(bus_clk), .bus_rst(bus_rst),
        .i_cmd_tdata(set_tdata), .i_cmd_tlast(set_tlast),
        .i_cmd_tvalid(set_tvalid), .o_cmd_tready(set_tready),
        .o_resp_tdata(s0_resp_tdata), .o_resp_tlast(s0_resp_tlast),
        .o_resp_tvalid(s0_resp_tvalid), .i_resp_tready(s0_resp_tready),
        .i_rb_misc(i_rb_misc), .i_lock_signals(i_lock_signals),
        .o_misc_outs(o_misc_outs), .o_pps_select(o_pps_select),
        .o_time_sync(o_time_sync)
    );

    // second radio is not fitted, its control port echoes packets back
    ctrl_fifo loopback_fifo_i (
        .bus_clk(bus_clk), .bus_rst(bus_rst),
        .i_tdata(loop_tdata), .i_tlast(loop_tlast),
        .i_tvalid(loop_tvalid), .o_tready(loop_tready),
        .o_tdata(s1_resp_tdata), .o_tlast(s1_resp_tlast),
        .o_tvalid(s1_resp_tvalid), .i_tready(s1_resp_tready)
    );

    resp_arbiter resp_arbiter_i (
        .bus_clk(bus_clk), .bus_rst(bus_rst),
        .i_s0_resp_tdata(s0_resp_tdata), .i_s0_resp_tlast(s0_resp_tlast),
        .i_s0_resp_tvalid(s0_resp_tvalid), .o_s0_resp_tready(s0_resp_tready),
        .i_s1_resp_tdata(s1_resp_tdata), .i_s1_resp_tlast(s1_resp_tlast),
        .i_s1_resp_tvalid(s1_resp_tvalid), .o_s1_resp_tready(s1_resp_tready),
        .o_resp_tdata(o_resp_tdata), .o_resp_tlast(o_resp_tlast),
        .o_resp_tvalid(o_resp_tvalid), .i_resp_tready(i_resp_tready)
    );

endmodule

// File: logic/ctrl_demux.sv
// packet demux for the control stream, sends each packet to settings or loopback by header SID
`timescale 1ns/1ps
`include "core_consts.svh"

module ctrl_demux (
    input  logic        bus_clk,
    input  logic        bus_rst,
    input  logic [63:0] i_tdata,
    input  logic        i_tlast,
    input  logic        i_tvalid,
    output logic        o_tready,
    output logic [63:0] o_set_tdata,
    output logic        o_set_tlast,
    output logic        o_set_tvalid,
    input  logic        i_set_tready,
    output logic [63:0] o_loop_tdata,
    output logic        o_loop_tlast,
    output logic        o_loop_tvalid,
    input  logic        i_loop_tready
);

    core_pkg::ctrl_word_u hdr_word;
    core_pkg::peer_sel_e  hdr_dest;
    core_pkg::peer_sel_e  held_dest;
    core_pkg::peer_sel_e  cur_dest;
    logic                 sop;
    logic                 in_xfer;

    // decode the word as a header, only meaningful while sop is set
    assign hdr_word = i_tdata;
    assign hdr_dest = ((hdr_word.hdr.dst_sid[7:0] & `CORE_SID_MASK) == `CORE_LOOPBACK_SID) ?
                      core_pkg::PEER_LOOPBACK : core_pkg::PEER_SETTINGS;

    assign cur_dest = sop ? hdr_dest : held_dest;

    // data fans out, only the chosen side sees valid
    assign o_set_tdata   = i_tdata;
    assign o_set_tlast   = i_tlast;
    assign o_set_tvalid  = i_tvalid & (cur_dest == core_pkg::PEER_SETTINGS);
    assign o_loop_tdata  = i_tdata;
    assign o_loop_tlast  = i_tlast;
    assign o_loop_tvalid = i_tvalid & (cur_dest == core_pkg::PEER_LOOPBACK);

    assign o_tready = (cur_dest == core_pkg::PEER_LOOPBACK) ? i_loop_tready : i_set_tready;
    assign in_xfer  = i_tvalid & o_tready;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            sop       <= 1'b1;
            held_dest <= core_pkg::PEER_SETTINGS;
        end else if (in_xfer) begin
            // next word after tlast is a new header
            sop <= i_tlast;
            if (sop) begin
                held_dest <= hdr_dest;
            end
        end
    end

endmodule

// File: logic/ctrl_fifo.sv
// synchronous stream FIFO of tlast plus 64-bit data, used for timing and as the loopback peer
`timescale 1ns/1ps
`include "core_consts.svh"

module ctrl_fifo #(
    parameter int depth_log2 = `CORE_FIFO_DEPTH_LOG2
) (
    input  logic        bus_clk,
    input  logic        bus_rst,
    input  logic [63:0] i_tdata,
    input  logic        i_tlast,
    input  logic        i_tvalid,
    output logic        o_tready,
    output logic [63:0] o_tdata,
    output logic        o_tlast,
    output logic        o_tvalid,
    input  logic        i_tready
);

    localparam int depth = 1 << depth_log2;

    logic [64:0]           mem [depth];
    logic [depth_log2-1:0] wr_ptr;
    logic [depth_log2-1:0] rd_ptr;
    logic [depth_log2:0]   count;
    logic                  do_wr;
    logic                  do_rd;

    // count never exceeds depth, so the top bit alone means full
    assign o_tready = ~count[depth_log2];
    assign o_tvalid = (count != '0);

    assign do_wr = i_tvalid & o_tready;
    assign do_rd = o_tvalid & i_tready;

    // head word, visible the cycle after it is written
    assign {o_tlast, o_tdata} = mem[rd_ptr];

    always_ff @(posedge bus_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= {i_tlast, i_tdata};
        end
    end

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the fill level alone
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (!do_wr && do_rd) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: logic/resp_arbiter.sv
// round-robin packet arbiter that merges the two peer response streams onto the response bus
`timescale 1ns/1ps

module resp_arbiter (
    input  logic        bus_clk,
    input  logic        bus_rst,
    input  logic [63:0] i_s0_resp_tdata,
    input  logic        i_s0_resp_tlast,
    input  logic        i_s0_resp_tvalid,
    output logic        o_s0_resp_tready,
    input  logic [63:0] i_s1_resp_tdata,
    input  logic        i_s1_resp_tlast,
    input  logic        i_s1_resp_tvalid,
    output logic        o_s1_resp_tready,
    output logic [63:0] o_resp_tdata,
    output logic        o_resp_tlast,
    output logic        o_resp_tvalid,
    input  logic        i_resp_tready
);

    logic [1:0]          req;
    logic                busy_q;
    logic                end_xfer;
    core_pkg::peer_sel_e grant_q;
    core_pkg::peer_sel_e last_q;
    core_pkg::peer_sel_e pick;
    core_pkg::peer_sel_e after_last;
    core_pkg::peer_sel_e after_grant;

    // s0 is the settings peer, s1 the loopback peer
    assign req = {i_s1_resp_tvalid, i_s0_resp_tvalid};

    assign after_last  = core_pkg::peer_sel_e'(~last_q);
    assign after_grant = core_pkg::peer_sel_e'(~grant_q);

    // favour the peer not served last
    assign pick = req[after_last] ? after_last : last_q;

    ////////////////////////////////////////
    // data path, follows the held grant
    ////////////////////////////////////////

    assign o_resp_tdata  = (grant_q == core_pkg::PEER_LOOPBACK) ? i_s1_resp_tdata
                                                                 : i_s0_resp_tdata;
    assign o_resp_tlast  = (grant_q == core_pkg::PEER_LOOPBACK) ? i_s1_resp_tlast
                                                                 : i_s0_resp_tlast;
    assign o_resp_tvalid = busy_q & req[grant_q];

    assign o_s0_resp_tready = busy_q & (grant_q == core_pkg::PEER_SETTINGS) & i_resp_tready;
    assign o_s1_resp_tready = busy_q & (grant_q == core_pkg::PEER_LOOPBACK) & i_resp_tready;

    assign end_xfer = o_resp_tvalid & i_resp_tready & o_resp_tlast;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            busy_q  <= 1'b0;
            grant_q <= core_pkg::PEER_SETTINGS;
            last_q  <= core_pkg::PEER_LOOPBACK;
        end else if (!busy_q) begin
            if (|req) begin
                busy_q  <= 1'b1;
                grant_q <= pick;
            end
        end else if (end_xfer) begin
            last_q <= grant_q;
            // hand over straight away if the other side waits
            if (req[after_grant]) begin
                grant_q <= after_grant;
            end else begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule

// File: logic/settings_endpoint.sv
// settings peer: parses a command packet, writes core registers and answers with one readback
`timescale 1ns/1ps
`include "core_consts.svh"

module settings_endpoint (
    input  logic        bus_clk,
    input  logic        bus_rst,
    input  logic [63:0] i_cmd_tdata,
    input  logic        i_cmd_tlast,
    input  logic        i_cmd_tvalid,
    output logic        o_cmd_tready,
    output logic [63:0] o_resp_tdata,
    output logic        o_resp_tlast,
    output logic        o_resp_tvalid,
    input  logic        i_resp_tready,
    input  logic [31:0] i_rb_misc,
    input  logic [1:0]  i_lock_signals,
    output logic [31:0] o_misc_outs,
    output logic [1:0]  o_pps_select,
    output logic        o_time_sync
);

    typedef enum logic [1:0] {
        ST_HDR,
        ST_CMD,
        ST_RESP_HDR,
        ST_RESP_DATA
    } state_e;

    state_e               state;
    core_pkg::ctrl_word_u cmd_word;
    core_pkg::ctrl_word_u hdr_q;
    core_pkg::ctrl_word_u resp_hdr;
    logic                 cmd_xfer;
    logic                 resp_xfer;
    logic                 set_stb;
    logic [31:0]          misc_q;
    logic [1:0]           rb_sel_q;
    logic [2:0]           sync_q;
    logic [1:0]           lock_state;
    logic [1:0]           lock_state_r;
    logic [63:0]          rb_data;

    ////////////////////////////////////////
    // packet FSM
    ////////////////////////////////////////

    // closed while a response is pending, so one packet at a time
    assign o_cmd_tready = (state == ST_HDR) || (state == ST_CMD);
    assign cmd_xfer     = i_cmd_tvalid & o_cmd_tready;
    assign resp_xfer    = o_resp_tvalid & i_resp_tready;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            state <= ST_HDR;
        end else begin
            case (state)
                ST_HDR: begin
                    if (cmd_xfer) begin
                        state <= i_cmd_tlast ? ST_RESP_HDR : ST_CMD;
                    end
                end
                ST_CMD: begin
                    // extra command words each act as a write
                    if (cmd_xfer && i_cmd_tlast) begin
                        state <= ST_RESP_HDR;
                    end
                end
                ST_RESP_HDR: begin
                    if (resp_xfer) begin
                        state <= ST_RESP_DATA;
                    end
                end
                ST_RESP_DATA: begin
                    if (resp_xfer) begin
                        state <= ST_HDR;
                    end
                end
                default: begin
                    state <= ST_HDR;
                end
            endcase
        end
    end

    always_ff @(posedge bus_clk) begin
        if ((state == ST_HDR) && cmd_xfer) begin
            hdr_q <= i_cmd_tdata;
        end
    end

    ////////////////////////////////////////
    // setting registers
    ////////////////////////////////////////

    assign cmd_word = i_cmd_tdata;
    assign set_stb  = (state == ST_CMD) && cmd_xfer;

    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            misc_q   <= '0;
            rb_sel_q <= '0;
            sync_q   <= '0;
        end else if (set_stb) begin
            case (cmd_word.cmd.set_addr)
                `SR_CORE_MISC:     misc_q   <= cmd_word.cmd.set_data;
                `SR_CORE_READBACK: rb_sel_q <= cmd_word.cmd.set_data[1:0];
                `SR_CORE_SYNC:     sync_q   <= cmd_word.cmd.set_data[2:0];
                default: begin
                end
            endcase
        end
    end

    assign o_misc_outs                 = misc_q;
    assign {o_time_sync, o_pps_select} = sync_q;

    // lock inputs come from the front end, two flops before use
    always_ff @(posedge bus_clk) begin
        if (bus_rst) begin
            lock_state   <= '0;
            lock_state_r <= '0;
        end else begin
            lock_state   <= i_lock_signals;
            lock_state_r <= lock_state;
        end
    end

    ////////////////////////////////////////
    // readback and response words
    ////////////////////////////////////////

    always_comb begin
        case (rb_sel_q)
            2'd0:    rb_data = {`CORE_COMPAT_MAGIC, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR};
            2'd1:    rb_data = {32'b0, misc_q};
            2'd2:    rb_data = {16'b0, `CORE_RADIO_STATUS, 8'b0, i_rb_misc};
            default: rb_data = {62'b0, lock_state_r};
        endcase
    end

    // reply goes back to the sender, same seq number
    always_comb begin
        resp_hdr             = hdr_q;
        resp_hdr.hdr.pkt_len = 16'd2;
        resp_hdr.hdr.src_sid = hdr_q.hdr.dst_sid;
        resp_hdr.hdr.dst_sid = hdr_q.hdr.src_sid;
    end

    assign o_resp_tvalid = (state == ST_RESP_HDR) || (state == ST_RESP_DATA);
    assign o_resp_tlast  = (state == ST_RESP_DATA);
    assign o_resp_tdata  = (state == ST_RESP_DATA) ? rb_data : resp_hdr;

endmodule

// File: sim.f
+incdir+include
logic/core_pkg.sv
logic/ctrl_fifo.sv
logic/ctrl_demux.sv
logic/settings_endpoint.sv
logic/resp_arbiter.sv
logic/ctrl_core.sv
testbench/ctrl_core_properties.sv
testbench/ctrl_core_tb.sv

// File: testbench/ctrl_core_properties.sv
// handshake assertions bound into the control core to watch its streams
`timescale 1ns/1ps

module ctrl_core_properties (
    input logic        bus_clk,
    input logic        bus_rst,
    input logic [63:0] i_s0_resp_tdata,
    input logic        i_s0_resp_tlast,
    input logic        i_s0_resp_tvalid,
    input logic        i_s0_resp_tready,
    input logic [63:0] o_resp_tdata,
    input logic        o_resp_tlast,
    input logic        o_resp_tvalid,
    input logic        i_resp_tready
);

    // a stalled response word stays in place
    resp_hold_a: assert property (@(posedge bus_clk) disable iff (bus_rst)
        (o_resp_tvalid && !i_resp_tready) |=>
        (o_resp_tvalid && $stable(o_resp_tdata) && $stable(o_resp_tlast)))
        else $error("response word changed while waiting for ready");

    // same rule for the settings peer ahead of the arbiter
    set_hold_a: assert property (@(posedge bus_clk) disable iff (bus_rst)
        (i_s0_resp_tvalid && !i_s0_resp_tready) |=>
        (i_s0_resp_tvalid && $stable(i_s0_resp_tdata) && $stable(i_s0_resp_tlast)))
        else $error("settings reply word changed while waiting for ready");

    rst_quiet_a: assert property (@(posedge bus_clk) bus_rst |=> !o_resp_tvalid)
        else $error("response valid during reset");

endmodule

bind ctrl_core ctrl_core_properties props_i (
    .bus_clk(bus_clk), .bus_rst(bus_rst),
    .i_s0_resp_tdata(s0_resp_tdata), .i_s0_resp_tlast(s0_resp_tlast),
    .i_s0_resp_tvalid(s0_resp_tvalid), .i_s0_resp_tready(s0_resp_tready),
    .o_resp_tdata(o_resp_tdata), .o_resp_tlast(o_resp_tlast),
    .o_resp_tvalid(o_resp_tvalid), .i_resp_tready(i_resp_tready)
);

// File: testbench/ctrl_core_tb.sv
// drives random packets into the control core and checks the responses against a reference model
`timescale 1ns/1ps
`include "core_consts.svh"

module ctrl_core_tb;

    localparam int          CLK_PERIOD  = 40;
    localparam int          NUM_PKTS    = 400;
    localparam int          WATCHDOG_NS = NUM_PKTS * 40 * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'hfb5b_e1ec;

    logic        bus_clk;
    logic        bus_rst;
    logic [63:0] i_ctrl_tdata;
    logic        i_ctrl_tlast;
    logic        i_ctrl_tvalid;
    logic        o_ctrl_tready;
    logic [63:0] o_resp_tdata;
    logic        o_resp_tlast;
    logic        o_resp_tvalid;
    logic        i_resp_tready = 1'b0;
    logic [31:0] i_rb_misc;
    logic [1:0]  i_lock_signals;
    logic [31:0] o_misc_outs;
    logic [1:0]  o_pps_select;
    logic        o_time_sync;

    integer      seed = SEED;
    integer      ready_seed = ~SEED;
    logic [31:0] ready_rnd;
    int          settings_pending = 0;
    int          error_count = 0;
    bit          end_reported = 1'b0;
    bit          in_pkt = 1'b0;
    bit          cur_loop = 1'b0;

    // expected words per peer, plus register state seen at each settings reply
    logic [63:0] exp_set_q[$];
    logic [63:0] exp_loop_q[$];
    logic [31:0] exp_misc_q[$];
    logic [2:0]  exp_sync_q[$];

    // model copy of the setting registers
    logic [31:0] m_misc = '0;
    logic [1:0]  m_rb_sel = '0;
    logic [2:0]  m_sync = '0;

    ctrl_core dut_i (
        .bus_clk(bus_clk), .bus_rst(bus_rst),
        .i_ctrl_tdata(i_ctrl_tdata), .i_ctrl_tlast(i_ctrl_tlast),
        .i_ctrl_tvalid(i_ctrl_tvalid), .o_ctrl_tready(o_ctrl_tready),
        .o_resp_tdata(o_resp_tdata), .o_resp_tlast(o_resp_tlast),
        .o_resp_tvalid(o_resp_tvalid), .i_resp_tready(i_resp_tready),
        .i_rb_misc(i_rb_misc), .i_lock_signals(i_lock_signals),
        .o_misc_outs(o_misc_outs), .o_pps_select(o_pps_select),
        .o_time_sync(o_time_sync)
    );

    initial begin
        bus_clk = 1'b0;
        forever #(CLK_PERIOD / 2) bus_clk = ~bus_clk;
    end

    task automatic report_error(input string msg);
        error_count++;
        end_reported = 1'b1;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopping at the first error");
    endtask

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [63:0] expected_readback();
        case (m_rb_sel)
            2'd0:    return {`CORE_COMPAT_MAGIC, `CORE_COMPAT_MAJOR, `CORE_COMPAT_MINOR};
            2'd1:    return {32'h0, m_misc};
            2'd2:    return {16'h0, `CORE_RADIO_STATUS, 8'h0, i_rb_misc};
            default: return {62'h0, i_lock_signals};
        endcase
    endfunction

    // random SID byte that never lands on the loopback peer
    function automatic logic [7:0] sid_off_loop();
        logic [31:0] r;
        r = $random(seed);
        while ((r[7:0] & `CORE_SID_MASK) == `CORE_LOOPBACK_SID) begin
            r = $random(seed);
        end
        return r[7:0];
    endfunction

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_word(input logic [63:0] data, input logic last);
        i_ctrl_tdata  = data;
        i_ctrl_tlast  = last;
        i_ctrl_tvalid = 1'b1;
        @(posedge bus_clk);
        while (!o_ctrl_tready) begin
            @(posedge bus_clk);
        end
        @(negedge bus_clk);
        i_ctrl_tvalid = 1'b0;
    endtask

    task automatic send_packet();
        logic [31:0] r;
        logic [15:0] seq;
        logic [15:0] src;
        logic [15:0] dst;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [63:0] hdr;
        logic [63:0] cmd;
        r   = $random(seed);
        seq = r[15:0];
        src = {r[31:24], sid_off_loop()};
        r   = $random(seed);
        case (r[1:0])
            2'd0, 2'd1: dst = {r[15:8], `CORE_SETTINGS_SID | {4'h0, r[19:16]}};
            2'd2:       dst = {r[15:8], `CORE_LOOPBACK_SID | {4'h0, r[19:16]}};
            default:    dst = {r[15:8], sid_off_loop()};
        endcase
        r = $random(seed);
        case (r[2:0])
            3'd0:       addr = `SR_CORE_MISC;
            3'd1, 3'd2: addr = `SR_CORE_READBACK;
            3'd3:       addr = `SR_CORE_SYNC;
            default:    addr = r[15:8];
        endcase
        data = $random(seed);
        hdr  = {seq, 16'd2, src, dst};
        cmd  = {r[31:8], addr, data};
        if ((dst[7:0] & `CORE_SID_MASK) == `CORE_LOOPBACK_SID) begin
            exp_loop_q.push_back(hdr);
            exp_loop_q.push_back(cmd);
        end else begin
            r = $random(seed);
            // new status inputs only while no settings reply is pending
            if (r[1:0] == 2'b00) begin
                while (settings_pending != 0) begin
                    @(negedge bus_clk);
                end
                i_rb_misc      = $random(seed);
                r              = $random(seed);
                i_lock_signals = r[1:0];
                repeat (4) @(negedge bus_clk);
            end
            case (addr)
                `SR_CORE_MISC:     m_misc   = data;
                `SR_CORE_READBACK: m_rb_sel = data[1:0];
                `SR_CORE_SYNC:     m_sync   = data[2:0];
                default: begin
                end
            endcase
            exp_set_q.push_back({seq, 16'd2, dst, src});
            exp_set_q.push_back(expected_readback());
            exp_misc_q.push_back(m_misc);
            exp_sync_q.push_back(m_sync);
            settings_pending++;
        end
        send_word(hdr, 1'b0);
        send_word(cmd, 1'b1);
        r = $random(seed);
        repeat (r[1:0]) @(negedge bus_clk);
    endtask

    always @(negedge bus_clk) begin
        ready_rnd     = $random(ready_seed);
        i_resp_tready = (ready_rnd[1:0] != 2'b00);
    end

    ////////////////////////////////////////
    // response monitor
    ////////////////////////////////////////

    task automatic check_word(input logic [63:0] data, input logic last);
        logic [63:0] exp;
        logic [31:0] misc_exp;
        logic [2:0]  sync_exp;
        if (!in_pkt) begin
            cur_loop = ((data[7:0] & `CORE_SID_MASK) == `CORE_LOOPBACK_SID);
            assert (last == 1'b0) else
                report_error($sformatf("Fail o_resp_tlast: got %h expected %h", last, 1'b0));
            if (cur_loop) begin
                assert (exp_loop_q.size() != 0) else
                    report_error("loopback response arrived with no loopback packet sent");
                exp = exp_loop_q.pop_front();
            end else begin
                assert (exp_set_q.size() != 0) else
                    report_error("settings response arrived with no settings packet sent");
                exp      = exp_set_q.pop_front();
                misc_exp = exp_misc_q.pop_front();
                sync_exp = exp_sync_q.pop_front();
                assert (o_misc_outs == misc_exp) else
                    report_error($sformatf("Fail o_misc_outs: got %h expected %h",
                                           o_misc_outs, misc_exp));
                assert (o_pps_select == sync_exp[1:0]) else
                    report_error($sformatf("Fail o_pps_select: got %h expected %h",
                                           o_pps_select, sync_exp[1:0]));
                assert (o_time_sync == sync_exp[2]) else
                    report_error($sformatf("Fail o_time_sync: got %h expected %h",
                                           o_time_sync, sync_exp[2]));
            end
            in_pkt = 1'b1;
        end else begin
            assert (last == 1'b1) else
                report_error($sformatf("Fail o_resp_tlast: got %h expected %h", last, 1'b1));
            exp    = cur_loop ? exp_loop_q.pop_front() : exp_set_q.pop_front();
            in_pkt = 1'b0;
            if (!cur_loop) begin
                settings_pending--;
            end
        end
        assert (data == exp) else
            report_error($sformatf("Fail o_resp_tdata: got %h expected %h", data, exp));
    endtask

    always @(posedge bus_clk) begin
        if (!bus_rst && o_resp_tvalid && i_resp_tready) begin
            check_word(o_resp_tdata, o_resp_tlast);
        end
    end

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        bus_rst        = 1'b1;
        i_ctrl_tdata   = '0;
        i_ctrl_tlast   = 1'b0;
        i_ctrl_tvalid  = 1'b0;
        i_rb_misc      = '0;
        i_lock_signals = '0;
        repeat (10) @(posedge bus_clk);
        @(negedge bus_clk);
        bus_rst = 1'b0;
        assert (o_misc_outs == 32'h0) else
            report_error($sformatf("Fail o_misc_outs: got %h expected %h", o_misc_outs, 32'h0));
        assert (o_pps_select == 2'h0) else
            report_error($sformatf("Fail o_pps_select: got %h expected %h", o_pps_select, 2'h0));
        assert (o_time_sync == 1'b0) else
            report_error($sformatf("Fail o_time_sync: got %h expected %h", o_time_sync, 1'b0));
        assert (o_resp_tvalid == 1'b0) else
            report_error("a response was valid straight after reset");
        for (int i = 0; i < NUM_PKTS; i++) begin
            send_packet();
        end
        while (exp_set_q.size() != 0 || exp_loop_q.size() != 0 || in_pkt) begin
            @(negedge bus_clk);
        end
        // quiet window, a stray extra reply would show up here
        repeat (10) @(negedge bus_clk);
        assert (o_resp_tvalid == 1'b0) else
            report_error("a response was valid after every expected response had arrived");
        end_reported = 1'b1;
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        report_error("timeout, not every packet got its response in time");
    end

    final begin
        if (!end_reported) begin
            $display("Test failures found");
        end
    end

endmodule
